//--- emtf_core_top.f
hw/emtf_pkg.sv
hw/ttc_cmd_stretch.sv
hw/link_hr_timer.sv
hw/lct_source_sel.sv
hw/track_word_serializer.sv
hw/emtf_core_top.sv
tb/emtf_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and judge the log

set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! verilator --binary --timing -j 0 --top-module emtf_tb \
	-f emtf_core_top.f -Mdir "$build_dir" -o emtf_sim; then
	echo "verilator build failed"
	exit 1
fi

"$build_dir/emtf_sim" > "$log_file" 2>&1
sim_status=$?

if ! cat "$log_file"; then
	echo "could not read $log_file"
	exit 1
fi

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

# the verdict comes from the log
if grep -qx "tests failed" "$log_file"; then
	echo "simulation reported a failure"
	exit 1
fi

echo "simulation finished without a reported failure"
exit 0

//--- tb/emtf_tb.sv
module emtf_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import emtf_pkg::*;

	typedef logic [127:0] chk_t;

	logic clk_160;
	logic ttc_hard_reset_rx;
	logic ttc_l1a_i, ttc_bc0_i, ttc_resync_i, ttc_ev_cnt_reset_i, ttc_or_cnt_reset_i;
	logic ttc_mpc_inject_i, ttc_hard_reset_i, mpc_inj_enable_i, local_inject_i;
	logic ttc_l1a_o, ttc_bc0_o, ttc_resync_o, ttc_ev_cnt_reset_o, ttc_or_cnt_reset_o;
	logic inject_start_o;
	hr_count_t mpc_link_hr_to_i;
	logic mpc_links_hr_en_i, mpc_links_reset_o, inj_enable_i;
	logic [INJECT_W-1:0] inject_data_i;
	stub_word_t [N_STUBS-1:0] mpc_stub_i;
	logic [N_STUBS*BW_QL-1:0] lct_ql_o;
	logic [N_STUBS*BW_CP-1:0] lct_cp_o;
	logic [N_STUBS*BW_WG-1:0] lct_wg_o;
	logic [N_STUBS*BW_HS-1:0] lct_hs_o;
	logic [N_STUBS-1:0] lct_vf_o;
	logic [N_TRACKS*BW_FPH-1:0] bt_phi_i;
	logic [N_TRACKS*BW_TH-1:0] bt_theta_i;
	logic [N_TRACKS*2*BW_FPH-1:0] bt_delta_ph_i;
	logic [N_TRACKS*2*BW_TH-1:0] bt_delta_th_i;
	logic [N_TRACKS*BW_RANK-1:0] bt_rank_i;
	logic [N_TRACKS*BW_PT-1:0] bt_pt_i;
	logic [N_TRACKS*BW_SEG-1:0] bt_si_i;
	logic [N_TRACKS*BW_SIGN-1:0] bt_sign_ph_i, bt_sign_th_i;
	logic [N_TRACKS*BW_CP-1:0] bt_cpattern_i;
	out_word_t word0_o, word1_o;
	spy_word_t spy_word_o;

	int unsigned err_cnt = 0;
	int unsigned check_cnt = 0;
	int unsigned timeout_cnt = 0;

	emtf_core_top uut (.*);

	initial
	begin
		clk_160 = 1'b0;
		forever #10 clk_160 = ~clk_160;
	end

	function automatic logic one_in(input int unsigned n);
		return ($urandom % n) == 0;
	endfunction

	task automatic check(input string name, input chk_t expected, input chk_t actual);
		check_cnt++;
		if (actual !== expected)
		begin
			err_cnt++;
			$display("ERR %s expected %0h actual %0h at %0t ns", name, expected, actual, $time);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference models
	//////////////////////////////////////////////////////////////////////

	// h[0] holds the inputs at edge m and the stretch covers m-2..m-4
	function automatic logic [N_TTC_CMD-1:0] stretch_ref(input logic [N_TTC_CMD-1:0] h [5]);
		return h[2] | h[3] | h[4];
	endfunction

	function automatic stub_word_t stub_ref(input int i);
		int chamber_idx;
		int seg;
		chamber_idx = i / SEG_CH;
		seg = i % SEG_CH; // upper stub in upper 24 bits of its chamber
		if (inj_enable_i)
			return inject_data_i[chamber_idx*CHAMBER_W + seg*STUB_W +: STUB_W];
		return mpc_stub_i[i];
	endfunction

	// {word1, word0} for one frame with frame 3 blank
	function automatic spy_word_t frame_ref(input int f);
		out_word_t w0;
		out_word_t w1;
		if (f >= N_TRACKS)
			return '0;
		w0 = out_word_t'(bt_phi_i[f*BW_FPH +: BW_FPH]);
		w0 |= out_word_t'(bt_delta_ph_i[2*f*BW_FPH +: BW_FPH]) << 12;
		w0 |= out_word_t'(bt_delta_ph_i[(2*f+1)*BW_FPH +: BW_FPH]) << 24;
		w0 |= out_word_t'(bt_theta_i[f*BW_TH +: BW_TH]) << 36;
		w0 |= out_word_t'(bt_delta_th_i[2*f*BW_TH +: BW_TH]) << 43;
		w0 |= out_word_t'(bt_delta_th_i[(2*f+1)*BW_TH +: BW_TH]) << 50;
		w0 |= out_word_t'(bt_rank_i[f*BW_RANK +: BW_RANK]) << 57;
		w1 = out_word_t'(bt_cpattern_i[f*BW_CP +: BW_CP]);
		w1 |= out_word_t'(bt_sign_ph_i[f*BW_SIGN +: BW_SIGN]) << 4;
		w1 |= out_word_t'(bt_sign_th_i[f*BW_SIGN +: BW_SIGN]) << 10;
		w1 |= out_word_t'(bt_si_i[f*BW_SEG +: BW_SEG]) << 16;
		w1 |= out_word_t'(bt_pt_i[f*BW_PT +: BW_PT]) << 21;
		return {w1, w0};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// compare process samples 1 ns after each rising edge
	//////////////////////////////////////////////////////////////////////

	initial
	begin : compare
		logic [N_TTC_CMD-1:0] cmd_hist [5];
		spy_word_t pair_hist [3];
		logic [N_TTC_CMD-1:0] str_exp;
		logic [N_STUBS*BW_QL-1:0] ql_exp;
		logic [N_STUBS*BW_CP-1:0] cp_exp;
		logic [N_STUBS*BW_WG-1:0] wg_exp;
		logic [N_STUBS*BW_HS-1:0] hs_exp;
		logic [N_STUBS-1:0] vf_exp;
		spy_word_t pair_exp;
		stub_word_t s;
		int frame_exp;
		for (int i = 0; i < 5; i++)
			cmd_hist[i] = '0;
		for (int i = 0; i < 3; i++)
			pair_hist[i] = '0;
		frame_exp = 0;
		pair_exp = '0;
		forever
		begin
			@(posedge clk_160);
			#1;
			for (int i = 4; i > 0; i--)
				cmd_hist[i] = cmd_hist[i-1];
			cmd_hist[0] = {ttc_hard_reset_i, ttc_mpc_inject_i, ttc_or_cnt_reset_i,
				ttc_ev_cnt_reset_i, ttc_resync_i, ttc_bc0_i, ttc_l1a_i};
			if (ttc_hard_reset_rx)
			begin
				frame_exp = 0;
				pair_exp = '0; // words held low in reset
			end
			else
			begin
				str_exp = stretch_ref(cmd_hist);
				check("ttc_l1a_o", chk_t'(str_exp[0]), chk_t'(ttc_l1a_o));
				check("ttc_bc0_o", chk_t'(str_exp[1]), chk_t'(ttc_bc0_o));
				check("ttc_resync_o", chk_t'(str_exp[2]), chk_t'(ttc_resync_o));
				check("ttc_ev_cnt_reset_o", chk_t'(str_exp[3]), chk_t'(ttc_ev_cnt_reset_o));
				check("ttc_or_cnt_reset_o", chk_t'(str_exp[4]), chk_t'(ttc_or_cnt_reset_o));
				check("inject_start_o", chk_t'((str_exp[5] && mpc_inj_enable_i) || local_inject_i),
					chk_t'(inject_start_o));
				for (int i = 0; i < N_STUBS; i++)
				begin
					s = stub_ref(i);
					ql_exp[i*BW_QL +: BW_QL] = s[23:20];
					cp_exp[i*BW_CP +: BW_CP] = s[19:16];
					wg_exp[i*BW_WG +: BW_WG] = s[14:8];
					hs_exp[i*BW_HS +: BW_HS] = s[7:0];
					vf_exp[i] = s[23:20] != 4'd0;
				end
				check("lct_ql_o", chk_t'(ql_exp), chk_t'(lct_ql_o));
				check("lct_cp_o", chk_t'(cp_exp), chk_t'(lct_cp_o));
				check("lct_wg_o", chk_t'(wg_exp), chk_t'(lct_wg_o));
				check("lct_hs_o", chk_t'(hs_exp), chk_t'(lct_hs_o));
				check("lct_vf_o", chk_t'(vf_exp), chk_t'(lct_vf_o));
				pair_exp = frame_ref(frame_exp);
				check("word0_o", chk_t'(pair_exp[63:0]), chk_t'(word0_o));
				check("word1_o", chk_t'(pair_exp[127:64]), chk_t'(word1_o));
				check("spy_word_o", pair_hist[2], spy_word_o); // expected pair from three edges back
				frame_exp = (frame_exp + 1) % N_FRAMES;
			end
			pair_hist[2] = pair_hist[1];
			pair_hist[1] = pair_hist[0];
			pair_hist[0] = pair_exp;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers all drive on the falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic set_cmds(input logic [N_TTC_CMD-1:0] v);
		{ttc_hard_reset_i, ttc_mpc_inject_i, ttc_or_cnt_reset_i, ttc_ev_cnt_reset_i,
			ttc_resync_i, ttc_bc0_i, ttc_l1a_i} = v;
	endtask

	task automatic randomize_stubs();
		inj_enable_i = one_in(2);
		for (int i = 0; i < N_STUBS; i++)
		begin
			inject_data_i[i*STUB_W +: STUB_W] = stub_word_t'($urandom);
			mpc_stub_i[i] = stub_word_t'($urandom);
			if (one_in(4))
				inject_data_i[i*STUB_W + 20 +: 4] = '0; // empty stub
			if (one_in(4))
				mpc_stub_i[i][23:20] = '0;
		end
	endtask

	task automatic randomize_tracks();
		chk_t r [10];
		for (int i = 0; i < 10; i++)
			r[i] = {$urandom, $urandom, $urandom, $urandom};
		bt_phi_i = r[0][N_TRACKS*BW_FPH-1:0];
		bt_theta_i = r[1][N_TRACKS*BW_TH-1:0];
		bt_delta_ph_i = r[2][N_TRACKS*2*BW_FPH-1:0];
		bt_delta_th_i = r[3][N_TRACKS*2*BW_TH-1:0];
		bt_rank_i = r[4][N_TRACKS*BW_RANK-1:0];
		bt_pt_i = r[5][N_TRACKS*BW_PT-1:0];
		bt_si_i = r[6][N_TRACKS*BW_SEG-1:0];
		bt_sign_ph_i = r[7][N_TRACKS*BW_SIGN-1:0];
		bt_sign_th_i = r[8][N_TRACKS*BW_SIGN-1:0];
		bt_cpattern_i = r[9][N_TRACKS*BW_CP-1:0];
	endtask

	task automatic drive_cycle(input bit pulses);
		@(negedge clk_160);
		if (pulses)
			set_cmds({one_in(6), one_in(6), one_in(6), one_in(6), one_in(6), one_in(6),
				one_in(6)});
		else
			set_cmds('0);
		local_inject_i = one_in(4);
		randomize_stubs();
	endtask

	// two pulses on every command with gap cycles between them
	task automatic pulse_pair(input int gap);
		@(negedge clk_160);
		set_cmds('1);
		@(negedge clk_160);
		set_cmds('0);
		repeat (gap) @(negedge clk_160);
		set_cmds('1);
		@(negedge clk_160);
		set_cmds('0);
		repeat (6) @(negedge clk_160);
	endtask

	task automatic link_timer_case(input int unsigned to, input logic en);
		int unsigned n;
		int unsigned limit;
		int unsigned high_cycles;
		bit seen;
		@(negedge clk_160);
		mpc_link_hr_to_i = hr_count_t'(to);
		mpc_links_hr_en_i = en;
		ttc_hard_reset_i = 1'b1;
		@(negedge clk_160);
		ttc_hard_reset_i = 1'b0;
		limit = (to == 0 || !en) ? 60 : 12; // long window when it must stay low
		n = 0;
		seen = 1'b0;
		while (!seen && n < limit)
		begin
			@(posedge clk_160);
			#1;
			seen = mpc_links_reset_o;
			n++;
		end
		if (to == 0 || !en)
			check("mpc_links_reset_o", '0, chk_t'(seen));
		else if (!seen)
		begin
			$display("timeout: mpc link reset never rose for timeout %0d", to);
			timeout_cnt++;
		end
		else
		begin
			high_cycles = 1;
			n = 0;
			while (mpc_links_reset_o && n < to + 10)
			begin
				@(posedge clk_160);
				#1;
				if (mpc_links_reset_o)
					high_cycles++;
				n++;
			end
			if (mpc_links_reset_o)
			begin
				$display("timeout: mpc link reset stuck high for timeout %0d", to);
				timeout_cnt++;
			end
			else
				check("mpc_links_reset_o cycles", chk_t'(to + 2), chk_t'(high_cycles));
		end
		repeat (8) @(negedge clk_160);
	endtask

	initial
	begin : stimulus
		int unsigned rand_to;
		void'($urandom(32'h3bcf_7384));
		ttc_hard_reset_rx = 1'b1;
		set_cmds('0);
		mpc_inj_enable_i = 1'b1;
		local_inject_i = 1'b0;
		mpc_link_hr_to_i = '0; // timer stays quiet during the stretch phase
		mpc_links_hr_en_i = 1'b1;
		randomize_stubs();
		randomize_tracks();
		repeat (5) @(negedge clk_160);
		ttc_hard_reset_rx = 1'b0;

		repeat (150) drive_cycle(1'b1);
		for (int g = 0; g < 4; g++)
			pulse_pair(g);
		@(negedge clk_160);
		mpc_inj_enable_i = 1'b0;
		repeat (100) drive_cycle(1'b1);
		pulse_pair(1);
		randomize_tracks(); // new tracks while the spy line is full
		repeat (8) drive_cycle(1'b0);

		rand_to = 2 + $urandom % 39;
		link_timer_case(0, 1'b1);
		link_timer_case(1, 1'b1);
		link_timer_case(rand_to, 1'b1);
		link_timer_case(rand_to, 1'b0);
		link_timer_case(1, 1'b0);
		repeat (60) drive_cycle(1'b0);

		@(negedge clk_160);
		$display("checks %0d, errors %0d, timeouts %0d", check_cnt, err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- hw/emtf_core_top.sv
module emtf_core_top
(
	input  logic clk_160,
	input  logic ttc_hard_reset_rx,

	// ttc
	input  logic ttc_l1a_i,
	input  logic ttc_bc0_i,
	input  logic ttc_resync_i,
	input  logic ttc_ev_cnt_reset_i,
	input  logic ttc_or_cnt_reset_i,
	input  logic ttc_mpc_inject_i,
	input  logic ttc_hard_reset_i,
	input  logic mpc_inj_enable_i,
	input  logic local_inject_i,
	output logic ttc_l1a_o,
	output logic ttc_bc0_o,
	output logic ttc_resync_o,
	output logic ttc_ev_cnt_reset_o,
	output logic ttc_or_cnt_reset_o,
	output logic inject_start_o,

	// mpc link reset
	input  emtf_pkg::hr_count_t mpc_link_hr_to_i,
	input  logic                mpc_links_hr_en_i,
	output logic                mpc_links_reset_o,

	// stubs
	input  logic                                         inj_enable_i,
	input  logic [emtf_pkg::INJECT_W-1:0]                inject_data_i,
	input  emtf_pkg::stub_word_t [emtf_pkg::N_STUBS-1:0] mpc_stub_i,
	output logic [emtf_pkg::N_STUBS*emtf_pkg::BW_QL-1:0] lct_ql_o,
	output logic [emtf_pkg::N_STUBS*emtf_pkg::BW_CP-1:0] lct_cp_o,
	output logic [emtf_pkg::N_STUBS*emtf_pkg::BW_WG-1:0] lct_wg_o,
	output logic [emtf_pkg::N_STUBS*emtf_pkg::BW_HS-1:0] lct_hs_o,
	output logic [emtf_pkg::N_STUBS-1:0]                 lct_vf_o,

	// best tracks
	input  logic [emtf_pkg::N_TRACKS*emtf_pkg::BW_FPH-1:0]    bt_phi_i,
	input  logic [emtf_pkg::N_TRACKS*emtf_pkg::BW_TH-1:0]     bt_theta_i,
	input  logic [emtf_pkg::N_TRACKS*2*emtf_pkg::BW_FPH-1:0]  bt_delta_ph_i,
	input  logic [emtf_pkg::N_TRACKS*2*emtf_pkg::BW_TH-1:0]   bt_delta_th_i,
	input  logic [emtf_pkg::N_TRACKS*emtf_pkg::BW_RANK-1:0]   bt_rank_i,
	input  logic [emtf_pkg::N_TRACKS*emtf_pkg::BW_PT-1:0]     bt_pt_i,
	input  logic [emtf_pkg::N_TRACKS*emtf_pkg::BW_SEG-1:0]    bt_si_i,
	input  logic [emtf_pkg::N_TRACKS*emtf_pkg::BW_SIGN-1:0]   bt_sign_ph_i,
	input  logic [emtf_pkg::N_TRACKS*emtf_pkg::BW_SIGN-1:0]   bt_sign_th_i,
	input  logic [emtf_pkg::N_TRACKS*emtf_pkg::BW_CP-1:0]     bt_cpattern_i,
	output emtf_pkg::out_word_t word0_o,
	output emtf_pkg::out_word_t word1_o,
	output emtf_pkg::spy_word_t spy_word_o
);

	logic hard_reset_cmd; // stretched hard reset into the link timer

	ttc_cmd_stretch ttc_str
	(
		.clk_160 (clk_160), .ttc_hard_reset_rx (ttc_hard_reset_rx),
		.ttc_l1a_i (ttc_l1a_i), .ttc_bc0_i (ttc_bc0_i), .ttc_resync_i (ttc_resync_i),
		.ttc_ev_cnt_reset_i (ttc_ev_cnt_reset_i), .ttc_or_cnt_reset_i (ttc_or_cnt_reset_i),
		.ttc_mpc_inject_i (ttc_mpc_inject_i), .ttc_hard_reset_i (ttc_hard_reset_i),
		.mpc_inj_enable_i (mpc_inj_enable_i), .local_inject_i (local_inject_i),
		.ttc_l1a_o (ttc_l1a_o), .ttc_bc0_o (ttc_bc0_o), .ttc_resync_o (ttc_resync_o),
		.ttc_ev_cnt_reset_o (ttc_ev_cnt_reset_o), .ttc_or_cnt_reset_o (ttc_or_cnt_reset_o),
		.hard_reset_cmd_o (hard_reset_cmd), .inject_start_o (inject_start_o)
	);

	link_hr_timer hr_tmr
	(
		.clk_160 (clk_160), .ttc_hard_reset_rx (ttc_hard_reset_rx),
		.hard_reset_cmd_i (hard_reset_cmd), .mpc_link_hr_to_i (mpc_link_hr_to_i),
		.mpc_links_hr_en_i (mpc_links_hr_en_i), .mpc_links_reset_o (mpc_links_reset_o)
	);

	lct_source_sel lct_sel
	(
		.clk_160 (clk_160), .ttc_hard_reset_rx (ttc_hard_reset_rx),
		.inj_enable_i (inj_enable_i), .inject_data_i (inject_data_i),
		.mpc_stub_i (mpc_stub_i),
		.lct_ql_o (lct_ql_o), .lct_cp_o (lct_cp_o), .lct_wg_o (lct_wg_o),
		.lct_hs_o (lct_hs_o), .lct_vf_o (lct_vf_o)
	);

	track_word_serializer tws
	(
		.clk_160 (clk_160), .ttc_hard_reset_rx (ttc_hard_reset_rx),
		.bt_phi_i (bt_phi_i), .bt_theta_i (bt_theta_i),
		.bt_delta_ph_i (bt_delta_ph_i), .bt_delta_th_i (bt_delta_th_i),
		.bt_rank_i (bt_rank_i), .bt_pt_i (bt_pt_i), .bt_si_i (bt_si_i),
		.bt_sign_ph_i (bt_sign_ph_i), .bt_sign_th_i (bt_sign_th_i),
		.bt_cpattern_i (bt_cpattern_i),
		.word0_o (word0_o), .word1_o (word1_o), .spy_word_o (spy_word_o)
	);

endmodule

//--- hw/track_word_serializer.sv
module track_word_serializer
(
	input  logic clk_160,
	input  logic ttc_hard_reset_rx,

	// best tracks, track 0 in low bits
	input  logic [emtf_pkg::N_TRACKS*emtf_pkg::BW_FPH-1:0]    bt_phi_i,
	input  logic [emtf_pkg::N_TRACKS*emtf_pkg::BW_TH-1:0]     bt_theta_i,
	input  logic [emtf_pkg::N_TRACKS*2*emtf_pkg::BW_FPH-1:0]  bt_delta_ph_i,
	input  logic [emtf_pkg::N_TRACKS*2*emtf_pkg::BW_TH-1:0]   bt_delta_th_i,
	input  logic [emtf_pkg::N_TRACKS*emtf_pkg::BW_RANK-1:0]   bt_rank_i,
	input  logic [emtf_pkg::N_TRACKS*emtf_pkg::BW_PT-1:0]     bt_pt_i,
	input  logic [emtf_pkg::N_TRACKS*emtf_pkg::BW_SEG-1:0]    bt_si_i,
	input  logic [emtf_pkg::N_TRACKS*emtf_pkg::BW_SIGN-1:0]   bt_sign_ph_i,
	input  logic [emtf_pkg::N_TRACKS*emtf_pkg::BW_SIGN-1:0]   bt_sign_th_i,
	input  logic [emtf_pkg::N_TRACKS*emtf_pkg::BW_CP-1:0]     bt_cpattern_i,

	output emtf_pkg::out_word_t word0_o,
	output emtf_pkg::out_word_t word1_o,
	output emtf_pkg::spy_word_t spy_word_o
);
	import emtf_pkg::*;

	out_word_t frame_w0 [N_FRAMES];
	out_word_t frame_w1 [N_FRAMES];
	logic [$clog2(N_FRAMES)-1:0] frame;
	spy_word_t spy_r;
	spy_word_t spy_rr;

	//////////////////////////////////////////////////////////////////////
	// word assembly, all tracks at once
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int t = 0; t < N_FRAMES; t++)
		begin
			frame_w0[t] = '0; // trailing frame stays blank
			frame_w1[t] = '0;
		end
		for (int t = 0; t < N_TRACKS; t++)
		begin
			frame_w0[t] = {
				bt_rank_i[t*BW_RANK +: BW_RANK],
				bt_delta_th_i[(2*t+1)*BW_TH +: BW_TH],
				bt_delta_th_i[2*t*BW_TH +: BW_TH],
				bt_theta_i[t*BW_TH +: BW_TH],
				bt_delta_ph_i[(2*t+1)*BW_FPH +: BW_FPH],
				bt_delta_ph_i[2*t*BW_FPH +: BW_FPH],
				bt_phi_i[t*BW_FPH +: BW_FPH]
			};
			// zero pad on top through the cast
			frame_w1[t] = out_word_t'({
				bt_pt_i[t*BW_PT +: BW_PT],
				bt_si_i[t*BW_SEG +: BW_SEG],
				bt_sign_th_i[t*BW_SIGN +: BW_SIGN],
				bt_sign_ph_i[t*BW_SIGN +: BW_SIGN],
				bt_cpattern_i[t*BW_CP +: BW_CP]
			});
		end
	end

	// frame stepping and spy delay line
	always_ff @(posedge clk_160)
	begin
		if (ttc_hard_reset_rx)
		begin
			frame      <= '0;
			word0_o    <= '0;
			word1_o    <= '0;
			spy_r      <= '0;
			spy_rr     <= '0;
			spy_word_o <= '0;
		end
		else
		begin
			word0_o    <= frame_w0[frame];
			word1_o    <= frame_w1[frame];
			frame      <= frame + 1'b1; // wraps after blank frame
			spy_r      <= {word1_o, word0_o};
			spy_rr     <= spy_r;
			spy_word_o <= spy_rr;
		end
	end

endmodule

//--- hw/lct_source_sel.sv
module lct_source_sel
(
	input  logic clk_160,
	input  logic ttc_hard_reset_rx,

	input  logic                                         inj_enable_i,
	input  logic [emtf_pkg::INJECT_W-1:0]                inject_data_i,
	input  emtf_pkg::stub_word_t [emtf_pkg::N_STUBS-1:0] mpc_stub_i,

	output logic [emtf_pkg::N_STUBS*emtf_pkg::BW_QL-1:0] lct_ql_o,
	output logic [emtf_pkg::N_STUBS*emtf_pkg::BW_CP-1:0] lct_cp_o,
	output logic [emtf_pkg::N_STUBS*emtf_pkg::BW_WG-1:0] lct_wg_o,
	output logic [emtf_pkg::N_STUBS*emtf_pkg::BW_HS-1:0] lct_hs_o,
	output logic [emtf_pkg::N_STUBS-1:0]                 lct_vf_o
);
	import emtf_pkg::*;

	logic [CHAMBER_W-1:0] chamber [LCT_STATIONS*LCT_CHAMBERS];
	stub_word_t           sel_stub [N_STUBS];

	//////////////////////////////////////////////////////////////////////
	// split inject data, pick the source per stub
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int st = 0; st < LCT_STATIONS; st++)
		begin
			for (int ch = 0; ch < LCT_CHAMBERS; ch++)
			begin
				chamber[st*LCT_CHAMBERS+ch] =
					inject_data_i[(st*LCT_CHAMBERS+ch)*CHAMBER_W +: CHAMBER_W];
				for (int sg = 0; sg < SEG_CH; sg++) // higher stub sits higher
				begin
					sel_stub[(st*LCT_CHAMBERS+ch)*SEG_CH+sg] = inj_enable_i ?
						chamber[st*LCT_CHAMBERS+ch][sg*STUB_W +: STUB_W] :
						mpc_stub_i[(st*LCT_CHAMBERS+ch)*SEG_CH+sg];
				end
			end
		end
	end

	// registered unpack
	always_ff @(posedge clk_160)
	begin
		if (ttc_hard_reset_rx)
		begin
			lct_ql_o <= '0;
			lct_cp_o <= '0;
			lct_wg_o <= '0;
			lct_hs_o <= '0;
			lct_vf_o <= '0;
		end
		else
		begin
			for (int i = 0; i < N_STUBS; i++)
			begin
				lct_ql_o[i*BW_QL +: BW_QL] <= sel_stub[i][QL_LSB +: BW_QL];
				lct_cp_o[i*BW_CP +: BW_CP] <= sel_stub[i][CP_LSB +: BW_CP];
				lct_wg_o[i*BW_WG +: BW_WG] <= sel_stub[i][WG_LSB +: BW_WG];
				lct_hs_o[i*BW_HS +: BW_HS] <= sel_stub[i][HS_LSB +: BW_HS];
				lct_vf_o[i] <= sel_stub[i][QL_LSB +: BW_QL] != '0; // valid = any quality
			end
		end
	end

endmodule

//--- hw/link_hr_timer.sv
module link_hr_timer
(
	input  logic                clk_160,
	input  logic                ttc_hard_reset_rx,
	input  logic                hard_reset_cmd_i, // stretched ttc hard reset
	input  emtf_pkg::hr_count_t mpc_link_hr_to_i, // timeout in clk_160 cycles
	input  logic                mpc_links_hr_en_i,
	output logic                mpc_links_reset_o
);
	import emtf_pkg::*;

	hr_count_t hr_cnt;
	hr_count_t hr_cnt_nxt;

	// reload while the command is up, then count down and stop at zero
	always_comb
	begin
		if (hard_reset_cmd_i)
			hr_cnt_nxt = mpc_link_hr_to_i;
		else if (hr_cnt != '0)
			hr_cnt_nxt = hr_cnt - hr_count_t'(1);
		else
			hr_cnt_nxt = hr_cnt;
	end

	always_ff @(posedge clk_160)
	begin
		if (ttc_hard_reset_rx)
		begin
			hr_cnt            <= '0;
			mpc_links_reset_o <= 1'b0;
		end
		else
		begin
			hr_cnt            <= hr_cnt_nxt;
			mpc_links_reset_o <= (hr_cnt_nxt != '0) && mpc_links_hr_en_i; // follows new count
		end
	end

endmodule

//--- hw/ttc_cmd_stretch.sv
module ttc_cmd_stretch
(
	input  logic clk_160,
	input  logic ttc_hard_reset_rx,

	// raw ttc pins
	input  logic ttc_l1a_i,
	input  logic ttc_bc0_i,
	input  logic ttc_resync_i,
	input  logic ttc_ev_cnt_reset_i,
	input  logic ttc_or_cnt_reset_i,
	input  logic ttc_mpc_inject_i,
	input  logic ttc_hard_reset_i,

	input  logic mpc_inj_enable_i,
	input  logic local_inject_i,

	output logic ttc_l1a_o,
	output logic ttc_bc0_o,
	output logic ttc_resync_o,
	output logic ttc_ev_cnt_reset_o,
	output logic ttc_or_cnt_reset_o,
	output logic hard_reset_cmd_o,
	output logic inject_start_o
);
	import emtf_pkg::*;

	logic [N_TTC_CMD-1:0] ttc_raw;
	logic [N_TTC_CMD-1:0] ttc_sr [TTC_DEPTH]; // [0] is the input capture
	logic [N_TTC_CMD-1:0] ttc_or;
	logic [N_TTC_CMD-1:0] ttc_str;
	logic mpc_inject_str;

	assign ttc_raw = {ttc_mpc_inject_i, ttc_or_cnt_reset_i, ttc_ev_cnt_reset_i,
		ttc_bc0_i, ttc_resync_i, ttc_l1a_i, ttc_hard_reset_i};

	// three cycles wide, overlapping pulses merge
	always_comb
	begin
		ttc_or = '0;
		for (int s = 1; s < TTC_DEPTH; s++)
			ttc_or |= ttc_sr[s];
	end

	always_ff @(posedge clk_160)
	begin
		if (ttc_hard_reset_rx)
		begin
			for (int s = 0; s < TTC_DEPTH; s++)
				ttc_sr[s] <= '0;
			ttc_str <= '0;
		end
		else
		begin
			ttc_sr[0] <= ttc_raw;
			for (int s = 1; s < TTC_DEPTH; s++)
				ttc_sr[s] <= ttc_sr[s-1];
			ttc_str <= ttc_or;
		end
	end

	assign {mpc_inject_str, ttc_or_cnt_reset_o, ttc_ev_cnt_reset_o,
		ttc_bc0_o, ttc_resync_o, ttc_l1a_o, hard_reset_cmd_o} = ttc_str;

	// ttc inject only when enabled, local request always
	assign inject_start_o = (mpc_inject_str && mpc_inj_enable_i) || local_inject_i;

endmodule

//--- hw/emtf_pkg.sv
package emtf_pkg;

	//////////////////////////////////////////////////////////////////////
	// ttc command pipeline
	//////////////////////////////////////////////////////////////////////

	localparam int N_TTC_CMD = 7; // l1a, bc0, resync, ev/or resets, inject, hard reset
	localparam int TTC_DEPTH = 4; // stages 1..3 feed the stretch

	//////////////////////////////////////////////////////////////////////
	// stub array, scaled down
	//////////////////////////////////////////////////////////////////////

	localparam int LCT_STATIONS = 2;
	localparam int LCT_CHAMBERS = 3;
	localparam int SEG_CH       = 2; // stubs per chamber
	localparam int N_STUBS      = LCT_STATIONS * LCT_CHAMBERS * SEG_CH;

	localparam int STUB_W    = 24;
	localparam int CHAMBER_W = SEG_CH * STUB_W; // upper stub in upper half
	localparam int INJECT_W  = N_STUBS * STUB_W;

	// stub layout {ql[3:0], cp[3:0], 1'b0, wg[6:0], hs[7:0]}
	localparam int BW_QL  = 4;
	localparam int BW_CP  = 4;
	localparam int BW_WG  = 7;
	localparam int BW_HS  = 8;
	localparam int QL_LSB = 20;
	localparam int CP_LSB = 16;
	localparam int WG_LSB = 8; // bit 15 is spare
	localparam int HS_LSB = 0;

	//////////////////////////////////////////////////////////////////////
	// best tracks and output words
	//////////////////////////////////////////////////////////////////////

	localparam int N_TRACKS = 3;
	localparam int N_FRAMES = 4; // last frame blank

	localparam int BW_FPH  = 12; // full precision phi
	localparam int BW_TH   = 7;
	localparam int BW_RANK = 7;
	localparam int BW_PT   = 9;
	localparam int BW_SEG  = 5;
	localparam int BW_SIGN = 6; // one sign per station pair

	localparam int OUT_W = 64;

	// mpc link reset timer
	localparam int HR_CNT_W = 24;

	typedef logic [STUB_W-1:0]    stub_word_t;
	typedef logic [OUT_W-1:0]     out_word_t;
	typedef logic [HR_CNT_W-1:0]  hr_count_t;
	typedef logic [2*OUT_W-1:0]   spy_word_t; // {word1, word0}

endpackage
